/* rtl/sysRegs_defs.svh */
//--------------------------------------
// Register map and bus sizes of the system control register block.
// Included by the package, the RTL and the testbench.
//--------------------------------------
`ifndef SYS_REGS_DEFS_SVH
`define SYS_REGS_DEFS_SVH

// Host bus widths.
`define SYS_ADDR_W 13          // Byte address into the register space.
`define SYS_DATA_W 32          // Four byte lanes.

// Register addresses, one 32-bit word each.
`define SYS_VERSION        13'h000
`define SYS_RESET          13'h004   // Lane-0 write fires a core reset.
`define SYS_TYPE           13'h008
`define SYS_SUBSYSTEM_CTRL 13'h00C
`define SYS_REBOOT_ADDR    13'h010   // Lane-3 write fires a reboot.
`define SYS_DAC_INPUT_SEL  13'h014
`define SYS_OUTPUT_SEL     13'h018

// Length of the core reset pulse in coreClk cycles.
`define SYS_CORE_RESET_CYCLES 6

`endif

/* rtl/sysRegsPkg.sv */
//--------------------------------------
// Types shared by the register block.
// Import with a wildcard in the module header.
//--------------------------------------
`include "sysRegs_defs.svh"

package sysRegsPkg;

    // Register selected by the current bus address.
    typedef enum logic [2:0] {
        regNone,
        regVersion,
        regReset,
        regType,
        regSubsysCtrl,
        regRebootAddr,
        regDacSel,
        regOutSel
    } regIdT;

    // One decoded bus access.
    typedef struct packed {
        regIdT                   regId;   // regNone when unmapped or not selected.
        logic [3:0]              lanes;   // Write strobes, zero without chip select.
        logic [`SYS_DATA_W-1:0]  data;    // Write data.
    } regAccessT;

    // Control fields held on the bus side.
    typedef struct packed {
        logic [2:0]  dac0Sel;
        logic [2:0]  dac1Sel;
        logic [2:0]  dac2Sel;
        logic [3:0]  ch0Mux;
        logic [3:0]  ch1Mux;
        logic        pngenEnable;
        logic        framerEnable;
        logic [31:0] rebootAddress;
    } ctrlRegsT;

endpackage

/* rtl/sysAddrDecode.sv */
//--------------------------------------
// Bus decode stage. Turns the address, chip select and strobes
// into one access record for the register bank and read mux.
//--------------------------------------
`timescale 1ns/1ps

`include "sysRegs_defs.svh"

module sysAddrDecode
    import sysRegsPkg::*;
(
    input  logic [`SYS_ADDR_W-1:0] addr,
    input  logic                   cs,
    input  logic [3:0]             wr,
    input  logic [`SYS_DATA_W-1:0] dataIn,
    output regAccessT              access
);

    always_comb begin
        access.regId = regNone;
        if (cs) begin
            case (addr)
                `SYS_VERSION:        access.regId = regVersion;
                `SYS_RESET:          access.regId = regReset;
                `SYS_TYPE:           access.regId = regType;
                `SYS_SUBSYSTEM_CTRL: access.regId = regSubsysCtrl;
                `SYS_REBOOT_ADDR:    access.regId = regRebootAddr;
                `SYS_DAC_INPUT_SEL:  access.regId = regDacSel;
                `SYS_OUTPUT_SEL:     access.regId = regOutSel;
                default:             access.regId = regNone;   // Unmapped.
            endcase
        end
        access.lanes = cs ? wr : 4'b0000;   // No strobes reach the bank without cs.
        access.data  = dataIn;
    end

endmodule

/* rtl/sysRegBank.sv */
//--------------------------------------
// Register bank. Applies byte-lane writes to the control fields
// and flips the request toggles for the core clock domain.
//--------------------------------------
`timescale 1ns/1ps

module sysRegBank
    import sysRegsPkg::*;
(
    input  logic      busClk,
    input  logic      rs,
    input  regAccessT access,
    output ctrlRegsT  ctrl,
    output logic      resetReqToggle,
    output logic      rebootReqToggle
);

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            ctrl            <= '0;
            resetReqToggle  <= 1'b0;
            rebootReqToggle <= 1'b0;
        end else begin
            case (access.regId)
                regReset: begin
                    if (access.lanes[0])
                        resetReqToggle <= ~resetReqToggle;   // One core reset per write.
                end
                regSubsysCtrl: begin
                    if (access.lanes[0]) begin
                        ctrl.framerEnable <= access.data[6];
                        ctrl.pngenEnable  <= access.data[7];
                    end
                end
                regRebootAddr: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (access.lanes[lane])
                            ctrl.rebootAddress[8*lane +: 8] <= access.data[8*lane +: 8];
                    end
                    // Top byte commits on this same edge, so the address is final.
                    if (access.lanes[3])
                        rebootReqToggle <= ~rebootReqToggle;
                end
                regDacSel: begin
                    if (access.lanes[0])
                        ctrl.dac0Sel <= access.data[2:0];
                    if (access.lanes[1])
                        ctrl.dac1Sel <= access.data[10:8];
                    if (access.lanes[2])
                        ctrl.dac2Sel <= access.data[18:16];
                end
                regOutSel: begin
                    if (access.lanes[0]) begin
                        ctrl.ch0Mux <= access.data[3:0];
                        ctrl.ch1Mux <= access.data[7:4];
                    end
                end
                default: ;   // Read-only or unmapped.
            endcase
        end
    end

    // The reboot request only moves after a top-byte write to the reboot register.
    assert property (@(posedge busClk) disable iff (rs)
        $changed(rebootReqToggle) |->
            $past(access.regId == regRebootAddr && access.lanes[3]))
        else $error("sysRegBank: reboot toggle moved without a lane-3 write");

endmodule

/* rtl/sysReadMux.sv */
//--------------------------------------
// Read result stage. Builds dataOut from the control fields,
// the version number and the FPGA type. Combinational.
//--------------------------------------
`timescale 1ns/1ps

`include "sysRegs_defs.svh"

module sysReadMux
    import sysRegsPkg::*;
(
    input  regAccessT                access,
    input  ctrlRegsT                 ctrl,
    input  logic [`SYS_DATA_W/2-1:0] versionNumber,
    input  logic [`SYS_DATA_W/2-1:0] fpgaType,
    output logic [`SYS_DATA_W-1:0]   dataOut
);

    always_comb begin
        dataOut = '0;   // Unmapped or unselected reads give zero.
        case (access.regId)
            regVersion, regReset:
                dataOut = {versionNumber, {(`SYS_DATA_W/2){1'b0}}};
            regType:
                dataOut = {{(`SYS_DATA_W/2){1'b0}}, fpgaType};
            regSubsysCtrl: begin
                dataOut[7] = ctrl.pngenEnable;
                dataOut[6] = ctrl.framerEnable;
            end
            regRebootAddr:
                dataOut = ctrl.rebootAddress;
            regDacSel: begin
                dataOut[2:0]   = ctrl.dac0Sel;
                dataOut[10:8]  = ctrl.dac1Sel;
                dataOut[18:16] = ctrl.dac2Sel;
            end
            regOutSel: begin
                dataOut[3:0] = ctrl.ch0Mux;
                dataOut[7:4] = ctrl.ch1Mux;
            end
            default: dataOut = '0;
        endcase
    end

endmodule

/* rtl/sysCoreEvents.sv */
//--------------------------------------
// Moves the reset and reboot requests into coreClk.
// Each toggle is synchronized, edge detected and shaped into a pulse.
//--------------------------------------
`timescale 1ns/1ps

`include "sysRegs_defs.svh"

module sysCoreEvents (
    input  logic coreClk,
    input  logic rs,
    input  logic resetReqToggle,
    input  logic rebootReqToggle,
    output logic coreReset,
    output logic reboot
);

    localparam int CountW = $clog2(`SYS_CORE_RESET_CYCLES);

    logic [1:0]        syncA;      // First stage, bit 0 reset and bit 1 reboot.
    logic [1:0]        syncB;      // Second stage.
    logic [1:0]        lastSync;   // Previous value for edge detection.
    logic [1:0]        reqEdge;
    logic [CountW-1:0] resetCount;

    always_ff @(posedge coreClk or posedge rs) begin
        if (rs) begin
            syncA    <= 2'b00;
            syncB    <= 2'b00;
            lastSync <= 2'b00;
        end else begin
            syncA    <= {rebootReqToggle, resetReqToggle};
            syncB    <= syncA;
            lastSync <= syncB;
        end
    end

    assign reqEdge = syncB ^ lastSync;   // Either toggle direction is a request.

    always_ff @(posedge coreClk or posedge rs) begin
        if (rs) begin
            coreReset  <= 1'b0;
            resetCount <= '0;
            reboot     <= 1'b0;
        end else begin
            reboot <= reqEdge[1];
            if (reqEdge[0]) begin
                coreReset  <= 1'b1;
                resetCount <= CountW'(`SYS_CORE_RESET_CYCLES - 1);
            end else if (resetCount != '0) begin
                resetCount <= resetCount - 1'b1;
            end else begin
                coreReset <= 1'b0;   // Pulse ends after the last counted cycle.
            end
        end
    end

    // Each reboot request gives a single-cycle pulse.
    assert property (@(posedge coreClk) disable iff (rs) reboot |=> !reboot)
        else $error("sysCoreEvents: reboot held for two cycles");

endmodule

/* rtl/sysTopRegs.sv */
//--------------------------------------
// System control registers on the host bus, with core reset and
// reboot events in coreClk. Drives the control ports of the signal chain.
//--------------------------------------
`timescale 1ns/1ps

`include "sysRegs_defs.svh"

module sysTopRegs
    import sysRegsPkg::*;
(
    input  logic                     busClk,
    input  logic                     rs,
    input  logic [`SYS_ADDR_W-1:0]   addr,
    input  logic [`SYS_DATA_W-1:0]   dataIn,
    output logic [`SYS_DATA_W-1:0]   dataOut,
    input  logic                     cs,
    input  logic [3:0]               wr,
    input  logic                     coreClk,
    input  logic [`SYS_DATA_W/2-1:0] versionNumber,
    input  logic [`SYS_DATA_W/2-1:0] fpgaType,
    output logic                     coreReset,
    output logic                     reboot,
    output logic [31:0]              rebootAddress,
    output logic [2:0]               dac0InputSelect,
    output logic [2:0]               dac1InputSelect,
    output logic [2:0]               dac2InputSelect,
    output logic [3:0]               ch0MuxSelect,
    output logic [3:0]               ch1MuxSelect,
    output logic                     pngenEnable,
    output logic                     framerEnable
);

    regAccessT access;
    ctrlRegsT  ctrl;
    logic      resetReqToggle;
    logic      rebootReqToggle;

    sysAddrDecode i_sysAddrDecode (
        .addr   (addr),
        .cs     (cs),
        .wr     (wr),
        .dataIn (dataIn),
        .access (access)
    );

    sysRegBank i_sysRegBank (
        .busClk          (busClk),
        .rs              (rs),
        .access          (access),
        .ctrl            (ctrl),
        .resetReqToggle  (resetReqToggle),
        .rebootReqToggle (rebootReqToggle)
    );

    sysReadMux i_sysReadMux (
        .access        (access),
        .ctrl          (ctrl),
        .versionNumber (versionNumber),
        .fpgaType      (fpgaType),
        .dataOut       (dataOut)
    );

    sysCoreEvents i_sysCoreEvents (
        .coreClk         (coreClk),
        .rs              (rs),
        .resetReqToggle  (resetReqToggle),
        .rebootReqToggle (rebootReqToggle),
        .coreReset       (coreReset),
        .reboot          (reboot)
    );

    // Control fields out to the signal chain.
    assign rebootAddress   = ctrl.rebootAddress;
    assign dac0InputSelect = ctrl.dac0Sel;
    assign dac1InputSelect = ctrl.dac1Sel;
    assign dac2InputSelect = ctrl.dac2Sel;
    assign ch0MuxSelect    = ctrl.ch0Mux;
    assign ch1MuxSelect    = ctrl.ch1Mux;
    assign pngenEnable     = ctrl.pngenEnable;
    assign framerEnable    = ctrl.framerEnable;

endmodule

/* testbench/tbSysTopRegs.sv */
//----------------------------------------
// Testbench for the system control register block. Drives LFSR writes
// and reads on the host bus, checks the ports against a shadow model.
//----------------------------------------
`timescale 1ns/1ps

`include "sysRegs_defs.svh"

module tbSysTopRegs
    import sysRegsPkg::*;
();

    localparam logic [15:0] VersionValue  = 16'h0302;
    localparam logic [15:0] TypeValue     = 16'h0005;
    localparam int          TimeoutCycles = 3000;   // About five times the test length.

    logic                   busClk, coreClk, rs, cs;
    logic [3:0]             wr;
    logic [`SYS_ADDR_W-1:0] addr;
    logic [`SYS_DATA_W-1:0] dataIn, dataOut;
    logic                   coreReset, reboot, pngenEnable, framerEnable, prevReset, prevReboot;
    logic [31:0]            rebootAddress, lfsr;
    logic [2:0]             dac0InputSelect, dac1InputSelect, dac2InputSelect;
    logic [3:0]             ch0MuxSelect, ch1MuxSelect;
    ctrlRegsT               model;   // Shadow of the control fields.
    int                     expResets, expReboots, resetPulses, rebootPulses, cycleCount;

    sysTopRegs i_sysTopRegs (.*, .versionNumber(VersionValue), .fpgaType(TypeValue));

    initial begin
        busClk = 1'b0;
        forever #10 busClk = ~busClk;
    end

    initial begin
        coreClk = 1'b0;
        #4;   // Keeps the core edges off the bus edges.
        forever #7 coreClk = ~coreClk;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        reportFailure($sformatf("CHECK FAILED at %0d ns: %s expected 0x%0h, actual 0x%0h",
                                $time, name, expected, actual));
    endtask

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] bits;
        bits = 32'h0;
        for (int n = 0; n < count; n++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Register model updated by the byte-lane rules.
    always @(posedge busClk or posedge rs) begin
        if (rs) begin
            model      <= '0;
            expResets  <= 0;
            expReboots <= 0;
        end else if (cs) begin
            case (addr)
                `SYS_RESET:
                    if (wr[0]) expResets <= expResets + 1;
                `SYS_SUBSYSTEM_CTRL:
                    if (wr[0]) model.framerEnable <= dataIn[6];
                `SYS_REBOOT_ADDR: begin
                    for (int n = 0; n < 4; n++) begin
                        if (wr[n]) model.rebootAddress[8*n +: 8] <= dataIn[8*n +: 8];
                    end
                    if (wr[3]) expReboots <= expReboots + 1;
                end
                `SYS_DAC_INPUT_SEL: begin
                    if (wr[0]) model.dac0Sel <= dataIn[2:0];
                    if (wr[1]) model.dac1Sel <= dataIn[10:8];
                    if (wr[2]) model.dac2Sel <= dataIn[18:16];
                end
                `SYS_OUTPUT_SEL:
                    if (wr[0]) model.ch0Mux <= dataIn[3:0];
                default: ;
            endcase
            if (addr == `SYS_SUBSYSTEM_CTRL && wr[0]) model.pngenEnable <= dataIn[7];
            if (addr == `SYS_OUTPUT_SEL && wr[0]) model.ch1Mux <= dataIn[7:4];
        end
    end

    function automatic logic [31:0] expectedRead(input logic [`SYS_ADDR_W-1:0] a);
        case (a)
            `SYS_VERSION, `SYS_RESET: return {VersionValue, 16'h0000};
            `SYS_TYPE:                return {16'h0000, TypeValue};
            `SYS_SUBSYSTEM_CTRL:      return {24'h0, model.pngenEnable, model.framerEnable, 6'h0};
            `SYS_REBOOT_ADDR:         return model.rebootAddress;
            `SYS_DAC_INPUT_SEL:
                return {13'h0, model.dac2Sel, 5'h0, model.dac1Sel, 5'h0, model.dac0Sel};
            `SYS_OUTPUT_SEL:          return {24'h0, model.ch1Mux, model.ch0Mux};
            default:                  return 32'h0;
        endcase
    endfunction

    // Rising edges of the core pulses.
    always @(posedge coreClk or posedge rs) begin
        if (rs) begin
            {prevReset, prevReboot} <= 2'b00;
            resetPulses             <= 0;
            rebootPulses            <= 0;
        end else begin
            {prevReset, prevReboot} <= {coreReset, reboot};
            if (coreReset && !prevReset) resetPulses <= resetPulses + 1;
            if (reboot && !prevReboot) rebootPulses <= rebootPulses + 1;
        end
    end

    always @(posedge busClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
            reportFailure($sformatf("Timeout after %0d busClk cycles.", TimeoutCycles));
    end

    assert property (@(posedge busClk) disable iff (rs) rebootAddress == model.rebootAddress)
        else reportMismatch("rebootAddress", $sampled(model.rebootAddress),
                            $sampled(rebootAddress));
    assert property (@(posedge busClk) disable iff (rs)
        {dac2InputSelect, dac1InputSelect, dac0InputSelect} ==
        {model.dac2Sel, model.dac1Sel, model.dac0Sel})
        else reportMismatch("dac2/dac1/dac0InputSelect",
            32'($sampled({model.dac2Sel, model.dac1Sel, model.dac0Sel})),
            32'($sampled({dac2InputSelect, dac1InputSelect, dac0InputSelect})));
    assert property (@(posedge busClk) disable iff (rs)
        {ch1MuxSelect, ch0MuxSelect, pngenEnable, framerEnable} ==
        {model.ch1Mux, model.ch0Mux, model.pngenEnable, model.framerEnable})
        else reportMismatch("ch1/ch0MuxSelect, pngen/framerEnable",
            32'($sampled({model.ch1Mux, model.ch0Mux, model.pngenEnable, model.framerEnable})),
            32'($sampled({ch1MuxSelect, ch0MuxSelect, pngenEnable, framerEnable})));
    assert property (@(posedge coreClk) disable iff (rs)
        reboot |-> rebootAddress == model.rebootAddress)
        else reportMismatch("rebootAddress at reboot", $sampled(model.rebootAddress),
                            $sampled(rebootAddress));

    task automatic writeReg(input logic [`SYS_ADDR_W-1:0] a, input logic [3:0] lanes,
                            input logic [31:0] data);
        @(posedge busClk);
        addr   <= a;
        wr     <= lanes;
        dataIn <= data;
        cs     <= 1'b1;
        @(posedge busClk);
        cs <= 1'b0;
        wr <= 4'b0000;
    endtask

    // Read with cs high, or a strobed access with cs low that must be ignored.
    task automatic probeBus(input logic [`SYS_ADDR_W-1:0] a, input logic csLevel);
        @(posedge busClk);
        addr   <= a;
        wr     <= csLevel ? 4'b0000 : 4'b1111;
        dataIn <= randomBits(32);
        cs     <= csLevel;
        @(negedge busClk);
        assert (dataOut == (csLevel ? expectedRead(a) : 32'h0))
            else reportMismatch("dataOut", csLevel ? expectedRead(a) : 32'h0, dataOut);
        @(posedge busClk);
        cs <= 1'b0;
        wr <= 4'b0000;
    endtask

    task automatic checkCorePulse(input logic resetPulse);
        int edges;
        int width;
        edges = 0;
        width = 0;
        while (!(resetPulse ? coreReset : reboot) && edges < 5) begin
            @(posedge coreClk);
            edges++;
            @(negedge coreClk);
        end
        assert (resetPulse ? coreReset : reboot)
            else reportFailure("A core event pulse did not rise within 5 coreClk edges.");
        while ((resetPulse ? coreReset : reboot) && width < 20) begin
            width++;
            @(negedge coreClk);
        end
        assert (width == (resetPulse ? `SYS_CORE_RESET_CYCLES : 1))
            else reportMismatch(resetPulse ? "coreReset width" : "reboot width",
                                resetPulse ? `SYS_CORE_RESET_CYCLES : 1, 32'(width));
    endtask

    task automatic settleCore();
        repeat (12) @(posedge coreClk);
        @(negedge coreClk);
        assert (resetPulses == expResets)
            else reportMismatch("coreReset pulses", 32'(expResets), 32'(resetPulses));
        assert (rebootPulses == expReboots)
            else reportMismatch("reboot pulses", 32'(expReboots), 32'(rebootPulses));
    endtask

    initial begin
        logic [`SYS_ADDR_W-1:0] target;
        logic [3:0]             lanes;
        logic [`SYS_ADDR_W-1:0] unmapped [4];
        unmapped = '{13'h01C, 13'h002, 13'h100, 13'h1FFC};
        lfsr     = 32'h6974;
        rs     <= 1'b1;
        cs     <= 1'b0;
        wr     <= 4'b0000;
        addr   <= '0;
        dataIn <= '0;
        repeat (16) @(posedge busClk);
        rs <= 1'b0;
        @(negedge busClk);
        assert (!coreReset && !reboot) else reportFailure("Core events active after reset.");
        probeBus(`SYS_VERSION, 1'b1);
        probeBus(`SYS_RESET, 1'b1);
        probeBus(`SYS_TYPE, 1'b1);
        for (int i = 0; i < 120; i++) begin
            lanes  = 4'(randomBits(4));
            target = 13'(`SYS_SUBSYSTEM_CTRL + 13'(4 * randomBits(2)));   // 0x00C to 0x018.
            if (target == `SYS_REBOOT_ADDR)
                lanes[3] = 1'b0;   // Top byte fires a reboot.
            writeReg(target, lanes, randomBits(32));
            probeBus(target, 1'b1);
        end
        foreach (unmapped[k]) begin
            writeReg(unmapped[k], 4'b1111, randomBits(32));
            probeBus(unmapped[k], 1'b1);
        end
        probeBus(`SYS_DAC_INPUT_SEL, 1'b0);
        probeBus(`SYS_VERSION, 1'b0);
        writeReg(`SYS_RESET, 4'b0001, randomBits(32));
        checkCorePulse(1'b1);
        settleCore();
        writeReg(`SYS_RESET, 4'b1110, randomBits(32));
        settleCore();
        writeReg(`SYS_REBOOT_ADDR, 4'b1000, randomBits(32));
        checkCorePulse(1'b0);
        settleCore();
        writeReg(`SYS_REBOOT_ADDR, 4'b1111, randomBits(32));
        checkCorePulse(1'b0);
        writeReg(`SYS_REBOOT_ADDR, 4'b0111, randomBits(32));
        probeBus(`SYS_REBOOT_ADDR, 1'b1);
        settleCore();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/sysRegsPkg.sv
rtl/sysAddrDecode.sv
rtl/sysRegBank.sv
rtl/sysReadMux.sv
rtl/sysCoreEvents.sv
rtl/sysTopRegs.sv
testbench/tbSysTopRegs.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbSysTopRegs
FILELIST = tb.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
